//--- tests/commit_vectors.txt
# ctl port fu0 fu1 op0 op1 rd0 rd1 res0 res1 cause0 cause1 tval0 csr_rdata csr_cause amo_res
#   ack gpr fpr wdata0 wdata1 csr_op csr_wdata oflags ex_cause ex_tval   (all hex, one cycle each)
18 00 0 0 00 00 05 06 11 22 00 00 70 c0 0c a0 0 0 0 11 22 00 0 000 00 0
18 11 3 3 00 50 05 06 11 22 00 00 70 c0 0c a0 3 1 2 11 22 00 0 080 00 0
18 11 3 3 50 00 05 06 11 22 00 00 70 c0 0c a0 3 2 1 11 22 00 0 080 00 0
1a 11 3 3 00 00 05 06 11 22 00 00 70 c0 0c a0 1 1 0 11 22 00 0 000 00 0
19 11 3 3 00 00 05 06 11 22 00 00 70 c0 0c a0 0 0 0 11 22 00 0 000 00 0
18 11 6 3 21 00 05 06 11 22 00 00 70 c0 0c a0 1 1 0 c0 22 21 11 002 00 0
10 01 2 0 10 00 05 06 11 22 00 00 70 c0 0c a0 0 1 0 11 22 00 0 000 00 0
18 01 2 0 10 00 05 06 11 22 00 00 70 c0 0c a0 1 1 0 11 22 00 0 004 00 0
08 01 3 0 01 00 05 06 11 22 00 00 70 c0 0c a0 0 1 0 11 22 00 0 000 00 0
18 01 3 0 01 00 05 06 11 22 00 00 70 c0 0c a0 1 1 0 11 22 00 0 020 00 0
08 01 3 0 02 00 05 06 11 22 00 00 70 c0 0c a0 0 1 0 11 22 00 0 000 00 0
18 01 3 0 02 00 05 06 11 22 00 00 70 c0 0c a0 1 1 0 11 22 00 0 040 00 0
18 11 2 3 30 00 05 06 11 22 00 00 70 c0 0c a0 0 0 0 11 22 00 0 008 00 0
38 11 2 3 30 00 05 06 11 22 00 00 70 c0 0c a0 1 1 0 a0 22 00 0 018 00 0
1c 01 6 0 21 00 05 06 11 22 00 00 70 c0 0c a0 0 0 0 11 22 21 11 100 0c 70
18 11 7 7 00 00 05 06 11 22 01 04 70 c0 0c a0 3 3 0 11 22 00 5 081 00 0
18 11 8 8 50 51 05 06 11 22 02 10 70 c0 0c a0 3 0 3 11 22 00 12 081 00 0
1c 03 3 0 00 00 05 06 11 22 02 00 70 c0 0c a0 0 0 0 11 22 00 0 100 02 70
18 07 3 0 00 00 05 06 11 22 02 00 70 c0 0c a0 1 0 0 11 22 00 0 000 00 0
19 03 3 0 00 00 05 06 11 22 02 00 70 c0 0c a0 0 0 0 11 22 00 0 000 00 0
18 11 3 2 00 00 05 06 11 22 00 00 70 c0 0c a0 1 1 0 11 22 00 0 000 00 0
18 11 3 7 00 00 05 06 11 22 00 04 70 c0 0c a0 3 3 0 11 22 00 4 081 00 0
18 00 0 0 00 00 05 06 11 22 00 00 70 c0 0c a0 0 0 0 11 22 00 0 000 00 0

//--- src.f
+incdir+include
verilog/commit_pkg.sv
verilog/commit_slot.sv
verilog/commit_exception.sv
verilog/commit_ctrl.sv
verilog/commit_stage.sv
tests/tb_commit_stage.sv

//--- Makefile
TOP := tb_commit_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

//--- tests/tb_commit_stage.sv
// commit stage testbench, replays tests/commit_vectors.txt and checks all outputs each cycle
`timescale 1ns/1ps
`include "commit_defines.svh"

module tb_commit_stage;

  import commit_pkg::*;

  localparam int NF = 26;
  localparam int MAX_VEC = 64;

  logic clk;
  logic load_done;
  int   n_vec;
  logic [31:0] vec_mem [0:MAX_VEC-1][0:NF-1];
  logic [31:0] f [0:NF-1];
  pc_t         exp_pc;
  trans_id_t   exp_id;

  // dut inputs
  logic halt_i, single_step_i;
  port_vec_t commit_valid_i, commit_ex_valid_i, commit_drop_i;
  fu_t       [`NR_COMMIT_PORTS-1:0] commit_fu_i;
  fu_op_t    [`NR_COMMIT_PORTS-1:0] commit_op_i;
  reg_addr_t [`NR_COMMIT_PORTS-1:0] commit_rd_i;
  xlen_t     [`NR_COMMIT_PORTS-1:0] commit_result_i, commit_ex_tval_i;
  cause_t    [`NR_COMMIT_PORTS-1:0] commit_ex_cause_i;
  trans_id_t [`NR_COMMIT_PORTS-1:0] commit_trans_id_i;
  pc_t       [`NR_COMMIT_PORTS-1:0] commit_pc_i;
  xlen_t  csr_rdata_i, amo_result_i;
  logic   csr_exception_valid_i, commit_lsu_ready_i, no_st_pending_i, amo_ack_i;
  cause_t csr_exception_cause_i;

  // dut outputs
  port_vec_t commit_ack_o, we_gpr_o, we_fpr_o;
  reg_addr_t [`NR_COMMIT_PORTS-1:0] waddr_o;
  xlen_t     [`NR_COMMIT_PORTS-1:0] wdata_o;
  pc_t       pc_o;
  trans_id_t commit_tran_id_o;
  fu_op_t    csr_op_o;
  xlen_t     csr_wdata_o, exception_tval_o;
  logic csr_write_fflags_o, commit_csr_o, dirty_fp_state_o, commit_lsu_o;
  logic amo_valid_commit_o, flush_commit_o, fence_o, fence_i_o, exception_valid_o;
  cause_t exception_cause_o;

  commit_stage dut (.*);

  // ----------------------------------------
  // clock, reset and watchdog
  // ----------------------------------------
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    int limit;
    wait (load_done);
    // one cycle per vector, plus reset and some slack
    limit = (n_vec + 4 + 4) * 20;
    #(limit);
    $display("watchdog expired before all vectors were applied");
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "output check failed");
    end
  endtask

  // everything idle, with the store buffer empty and ready
  task automatic clear_inputs();
    halt_i = 1'b0;
    single_step_i = 1'b0;
    commit_valid_i = '0;
    commit_ex_valid_i = '0;
    commit_drop_i = '0;
    commit_fu_i = '0;
    commit_op_i = '0;
    commit_rd_i = '0;
    commit_result_i = '0;
    commit_ex_tval_i = '0;
    commit_ex_cause_i = '0;
    commit_trans_id_i = '0;
    commit_pc_i = '0;
    csr_rdata_i = '0;
    amo_result_i = '0;
    csr_exception_valid_i = 1'b0;
    csr_exception_cause_i = '0;
    commit_lsu_ready_i = 1'b1;
    no_st_pending_i = 1'b1;
    amo_ack_i = 1'b0;
  endtask

  // ----------------------------------------
  // vector file
  // ----------------------------------------
  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    logic [31:0] t [0:NF-1];
    fd = $fopen("tests/commit_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file tests/commit_vectors.txt");
      $display("TEST FAIL");
      $fatal(1, "no vectors");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      // skip comments and blank lines
      if (line.len() < 2 || line.getc(0) == 8'h23) continue;
      cnt = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                    t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8], t[9], t[10],
                    t[11], t[12], t[13], t[14], t[15], t[16], t[17], t[18], t[19],
                    t[20], t[21], t[22], t[23], t[24], t[25]);
      if (cnt != NF || n_vec >= MAX_VEC) begin
        $display("malformed vector line %0d, found %0d fields", n_vec + 1, cnt);
        $display("TEST FAIL");
        $fatal(1, "bad vector file");
      end
      for (int k = 0; k < NF; k++) begin
        vec_mem[n_vec][k] = t[k];
      end
      n_vec++;
    end
    $fclose(fd);
    if (n_vec == 0) begin
      $display("the vector file tests/commit_vectors.txt holds no vectors");
      $display("TEST FAIL");
      $fatal(1, "empty vector file");
    end
  endtask

  // ----------------------------------------
  // drive and check
  // ----------------------------------------
  task automatic drive_vector(input int n);
    halt_i                = f[0][0];
    single_step_i         = f[0][1];
    csr_exception_valid_i = f[0][2];
    commit_lsu_ready_i    = f[0][3];
    no_st_pending_i       = f[0][4];
    amo_ack_i             = f[0][5];
    // port byte holds {drop, ex, valid} per nibble with port 0 in the low nibble
    commit_valid_i    = {f[1][4], f[1][0]};
    commit_ex_valid_i = {f[1][5], f[1][1]};
    commit_drop_i     = {f[1][6], f[1][2]};
    for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
      commit_fu_i[p]       = f[2+p][3:0];
      commit_op_i[p]       = f[4+p][7:0];
      commit_rd_i[p]       = f[6+p][4:0];
      commit_result_i[p]   = f[8+p];
      commit_ex_cause_i[p] = f[10+p][4:0];
    end
    commit_ex_tval_i[0] = f[12];
    commit_ex_tval_i[1] = 32'h0bad;
    csr_rdata_i = f[13];
    csr_exception_cause_i = f[14][4:0];
    amo_result_i = f[15];
    // pc and id walk with the vector index
    exp_pc = 32'h1000 + 32'(n) * 4;
    exp_id = 3'(n);
    commit_pc_i[0] = exp_pc;
    commit_pc_i[1] = exp_pc + 4;
    commit_trans_id_i[0] = exp_id;
    commit_trans_id_i[1] = exp_id + 3'd1;
  endtask

  task automatic check_outputs();
    check_value("commit_ack_o", f[16], 32'(commit_ack_o));
    check_value("we_gpr_o", f[17], 32'(we_gpr_o));
    check_value("we_fpr_o", f[18], 32'(we_fpr_o));
    check_value("wdata_o[0]", f[19], wdata_o[0]);
    check_value("wdata_o[1]", f[20], wdata_o[1]);
    check_value("waddr_o[0]", f[6], 32'(waddr_o[0]));
    check_value("waddr_o[1]", f[7], 32'(waddr_o[1]));
    check_value("pc_o", 32'(exp_pc), 32'(pc_o));
    check_value("commit_tran_id_o", 32'(exp_id), 32'(commit_tran_id_o));
    check_value("csr_op_o", f[21], 32'(csr_op_o));
    check_value("csr_wdata_o", f[22], csr_wdata_o);
    check_value("csr_write_fflags_o", 32'(f[23][0]), 32'(csr_write_fflags_o));
    check_value("commit_csr_o", 32'(f[23][1]), 32'(commit_csr_o));
    check_value("commit_lsu_o", 32'(f[23][2]), 32'(commit_lsu_o));
    check_value("amo_valid_commit_o", 32'(f[23][3]), 32'(amo_valid_commit_o));
    check_value("flush_commit_o", 32'(f[23][4]), 32'(flush_commit_o));
    check_value("fence_o", 32'(f[23][5]), 32'(fence_o));
    check_value("fence_i_o", 32'(f[23][6]), 32'(fence_i_o));
    check_value("dirty_fp_state_o", 32'(f[23][7]), 32'(dirty_fp_state_o));
    check_value("exception_valid_o", 32'(f[23][8]), 32'(exception_valid_o));
    // cause and tval only mean something with a trap
    if (f[23][8]) begin
      check_value("exception_cause_o", f[24], 32'(exception_cause_o));
      check_value("exception_tval_o", f[25], exception_tval_o);
    end
  endtask

  initial begin
    clear_inputs();
    load_done = 1'b0;
    n_vec = 0;
    load_vectors();
    load_done = 1'b1;
    // hold the inputs idle through the reset period
    repeat (4) @(posedge clk);
    for (int n = 0; n < n_vec; n++) begin
      @(posedge clk);
      #2;
      for (int k = 0; k < NF; k++) begin
        f[k] = vec_mem[n][k];
      end
      drive_vector(n);
      // sample just before the next edge
      #16;
      check_outputs();
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- verilog/commit_stage.sv
// two-port commit stage top: slot evaluators, retire controller and exception selector
`timescale 1ns/1ps
`include "commit_defines.svh"

module commit_stage (
  // core control
  input  logic                                       halt_i,
  input  logic                                       single_step_i,
  // scoreboard entries, one per port
  input  commit_pkg::port_vec_t                      commit_valid_i,
  input  commit_pkg::fu_t       [`NR_COMMIT_PORTS-1:0] commit_fu_i,
  input  commit_pkg::fu_op_t    [`NR_COMMIT_PORTS-1:0] commit_op_i,
  input  commit_pkg::reg_addr_t [`NR_COMMIT_PORTS-1:0] commit_rd_i,
  input  commit_pkg::xlen_t     [`NR_COMMIT_PORTS-1:0] commit_result_i,
  input  commit_pkg::port_vec_t                      commit_ex_valid_i,
  input  commit_pkg::cause_t    [`NR_COMMIT_PORTS-1:0] commit_ex_cause_i,
  input  commit_pkg::xlen_t     [`NR_COMMIT_PORTS-1:0] commit_ex_tval_i,
  input  commit_pkg::trans_id_t [`NR_COMMIT_PORTS-1:0] commit_trans_id_i,
  input  commit_pkg::pc_t       [`NR_COMMIT_PORTS-1:0] commit_pc_i,
  input  commit_pkg::port_vec_t                      commit_drop_i,
  // csr file
  input  commit_pkg::xlen_t                          csr_rdata_i,
  input  logic                                       csr_exception_valid_i,
  input  commit_pkg::cause_t                         csr_exception_cause_i,
  // load/store unit and cache
  input  logic                                       commit_lsu_ready_i,
  input  logic                                       no_st_pending_i,
  input  logic                                       amo_ack_i,
  input  commit_pkg::xlen_t                          amo_result_i,
  // issue stage and register files
  output commit_pkg::port_vec_t                      commit_ack_o,
  output commit_pkg::reg_addr_t [`NR_COMMIT_PORTS-1:0] waddr_o,
  output commit_pkg::xlen_t     [`NR_COMMIT_PORTS-1:0] wdata_o,
  output commit_pkg::port_vec_t                      we_gpr_o,
  output commit_pkg::port_vec_t                      we_fpr_o,
  output commit_pkg::pc_t                            pc_o,
  output commit_pkg::trans_id_t                      commit_tran_id_o,
  // csr file
  output commit_pkg::fu_op_t                         csr_op_o,
  output commit_pkg::xlen_t                          csr_wdata_o,
  output logic                                       csr_write_fflags_o,
  output logic                                       commit_csr_o,
  output logic                                       dirty_fp_state_o,
  // load/store unit and controller
  output logic                                       commit_lsu_o,
  output logic                                       amo_valid_commit_o,
  output logic                                       flush_commit_o,
  output logic                                       fence_o,
  output logic                                       fence_i_o,
  // trap request
  output logic                                       exception_valid_o,
  output commit_pkg::cause_t                         exception_cause_o,
  output commit_pkg::xlen_t                          exception_tval_o
);

  import commit_pkg::*;

  port_vec_t                       slot_ready;
  port_vec_t                       slot_fpr_dest;
  port_vec_t                       slot_fpu;
  port_vec_t                       slot_dual_ok;
  cause_t [`NR_COMMIT_PORTS-1:0]   slot_flags;

  // write address follows rd whether or not the port writes
  assign waddr_o          = commit_rd_i;
  // pc and id of the oldest entry
  assign pc_o             = commit_pc_i[0];
  assign commit_tran_id_o = commit_trans_id_i[0];

  // ----------------------------------------
  // per-port evaluation
  // ----------------------------------------
  for (genvar g = 0; g < `NR_COMMIT_PORTS; g++) begin : gen_slot
    commit_slot i_commit_slot (
      .valid_i    (commit_valid_i[g]),
      .fu_i       (commit_fu_i[g]),
      .op_i       (commit_op_i[g]),
      .ex_valid_i (commit_ex_valid_i[g]),
      .ex_cause_i (commit_ex_cause_i[g]),
      .drop_i     (commit_drop_i[g]),
      .ready_o    (slot_ready[g]),
      .fpr_dest_o (slot_fpr_dest[g]),
      .fpu_o      (slot_fpu[g]),
      .dual_ok_o  (slot_dual_ok[g]),
      .flags_o    (slot_flags[g])
    );
  end

  // ----------------------------------------
  // retire control
  // ----------------------------------------
  commit_ctrl i_commit_ctrl (
    .slot_ready_i          (slot_ready),
    .slot_fpr_dest_i       (slot_fpr_dest),
    .slot_fpu_i            (slot_fpu),
    .slot_dual_ok_i        (slot_dual_ok),
    .slot_flags_i          (slot_flags),
    .halt_i                (halt_i),
    .single_step_i         (single_step_i),
    .commit_drop_i         (commit_drop_i),
    .commit_fu_i           (commit_fu_i),
    .commit_op_i           (commit_op_i),
    .commit_result_i       (commit_result_i),
    .csr_rdata_i           (csr_rdata_i),
    .csr_exception_valid_i (csr_exception_valid_i),
    .commit_lsu_ready_i    (commit_lsu_ready_i),
    .no_st_pending_i       (no_st_pending_i),
    .amo_ack_i             (amo_ack_i),
    .amo_result_i          (amo_result_i),
    .exception_valid_i     (exception_valid_o),
    .commit_ack_o          (commit_ack_o),
    .we_gpr_o              (we_gpr_o),
    .we_fpr_o              (we_fpr_o),
    .wdata_o               (wdata_o),
    .csr_op_o              (csr_op_o),
    .csr_wdata_o           (csr_wdata_o),
    .csr_write_fflags_o    (csr_write_fflags_o),
    .commit_csr_o          (commit_csr_o),
    .commit_lsu_o          (commit_lsu_o),
    .amo_valid_commit_o    (amo_valid_commit_o),
    .flush_commit_o        (flush_commit_o),
    .fence_o               (fence_o),
    .fence_i_o             (fence_i_o),
    .dirty_fp_state_o      (dirty_fp_state_o)
  );

  // ----------------------------------------
  // exception at port 0
  // ----------------------------------------
  commit_exception i_commit_exception (
    .valid_i               (commit_valid_i[0]),
    .drop_i                (commit_drop_i[0]),
    .ex_valid_i            (commit_ex_valid_i[0]),
    .ex_cause_i            (commit_ex_cause_i[0]),
    .ex_tval_i             (commit_ex_tval_i[0]),
    .csr_exception_valid_i (csr_exception_valid_i),
    .csr_exception_cause_i (csr_exception_cause_i),
    .halt_i                (halt_i),
    .exception_valid_o     (exception_valid_o),
    .exception_cause_o     (exception_cause_o),
    .exception_tval_o      (exception_tval_o)
  );

endmodule

//--- verilog/commit_ctrl.sv
// retire decisions for both commit ports: acks, register writes, csr, store, fence and amo
`timescale 1ns/1ps
`include "commit_defines.svh"

module commit_ctrl (
  // per-port results from the slot evaluators
  input  commit_pkg::port_vec_t                      slot_ready_i,
  input  commit_pkg::port_vec_t                      slot_fpr_dest_i,
  input  commit_pkg::port_vec_t                      slot_fpu_i,
  input  commit_pkg::port_vec_t                      slot_dual_ok_i,
  input  commit_pkg::cause_t [`NR_COMMIT_PORTS-1:0]  slot_flags_i,
  // core control
  input  logic                                       halt_i,
  input  logic                                       single_step_i,
  input  commit_pkg::port_vec_t                      commit_drop_i,
  // scoreboard fields
  input  commit_pkg::fu_t    [`NR_COMMIT_PORTS-1:0]  commit_fu_i,
  input  commit_pkg::fu_op_t [`NR_COMMIT_PORTS-1:0]  commit_op_i,
  input  commit_pkg::xlen_t  [`NR_COMMIT_PORTS-1:0]  commit_result_i,
  // csr file
  input  commit_pkg::xlen_t                          csr_rdata_i,
  input  logic                                       csr_exception_valid_i,
  // load/store unit and cache
  input  logic                                       commit_lsu_ready_i,
  input  logic                                       no_st_pending_i,
  input  logic                                       amo_ack_i,
  input  commit_pkg::xlen_t                          amo_result_i,
  // trap taken at port 0
  input  logic                                       exception_valid_i,
  // issue stage and register files
  output commit_pkg::port_vec_t                      commit_ack_o,
  output commit_pkg::port_vec_t                      we_gpr_o,
  output commit_pkg::port_vec_t                      we_fpr_o,
  output commit_pkg::xlen_t  [`NR_COMMIT_PORTS-1:0]  wdata_o,
  // csr file
  output commit_pkg::fu_op_t                         csr_op_o,
  output commit_pkg::xlen_t                          csr_wdata_o,
  output logic                                       csr_write_fflags_o,
  output logic                                       commit_csr_o,
  // load/store unit and controller
  output logic                                       commit_lsu_o,
  output logic                                       amo_valid_commit_o,
  output logic                                       flush_commit_o,
  output logic                                       fence_o,
  output logic                                       fence_i_o,
  output logic                                       dirty_fp_state_o
);

  import commit_pkg::*;

  logic is_amo0;
  logic is_csr0;
  logic is_store0;
  logic port1_ok;

  // amos arrive through the store unit but retire on the cache ack
  assign is_amo0   = (commit_op_i[0][`FU_OP_BITS-1:`FU_OP_BITS-4] == `OP_AMO_GROUP);
  assign is_csr0   = (commit_fu_i[0] == `FU_CSR);
  assign is_store0 = (commit_fu_i[0] == `FU_STORE) && !is_amo0;

  // ----------------------------------------
  // port 0
  // ----------------------------------------
  always_comb begin : retire
    commit_ack_o       = '0;
    we_gpr_o           = '0;
    we_fpr_o           = '0;
    // amo result bypasses the alu result once the cache answers
    wdata_o[0]         = (is_amo0 && amo_ack_i) ? amo_result_i : commit_result_i[0];
    wdata_o[1]         = commit_result_i[1];
    csr_op_o           = `OP_ADD;
    csr_wdata_o        = '0;
    csr_write_fflags_o = 1'b0;
    commit_csr_o       = 1'b0;
    commit_lsu_o       = 1'b0;
    amo_valid_commit_o = 1'b0;
    flush_commit_o     = 1'b0;
    fence_o            = 1'b0;
    fence_i_o          = 1'b0;

    // halt holds everything in the scoreboard
    if (slot_ready_i[0] && !halt_i) begin
      commit_ack_o[0] = 1'b1;
      if (!commit_drop_i[0]) begin
        we_fpr_o[0] = slot_fpr_dest_i[0];
        we_gpr_o[0] = !slot_fpr_dest_i[0];
      end

      // store buffer full so hold the entry
      if (is_store0) begin
        commit_lsu_o    = commit_lsu_ready_i;
        commit_ack_o[0] = commit_lsu_ready_i;
      end

      // fflags from a retiring fpu op that is not dropped
      if (slot_fpu_i[0] && !commit_drop_i[0]) begin
        csr_wdata_o        = xlen_t'(slot_flags_i[0]);
        csr_write_fflags_o = 1'b1;
      end

      // csr op goes out even for a dropped entry but the commit does not
      if (is_csr0) begin
        csr_op_o    = commit_op_i[0];
        csr_wdata_o = commit_result_i[0];
        if (!commit_drop_i[0]) begin
          if (!csr_exception_valid_i) begin
            commit_csr_o = 1'b1;
            wdata_o[0]   = csr_rdata_i;
          end else begin
            commit_ack_o[0] = 1'b0;
            we_gpr_o[0]     = 1'b0;
          end
        end
      end

      // fences wait for the store buffer to drain
      if (commit_op_i[0] == `OP_FENCE_I && !commit_drop_i[0]) begin
        commit_ack_o[0] = no_st_pending_i;
        fence_i_o       = no_st_pending_i;
      end
      if (commit_op_i[0] == `OP_FENCE && !commit_drop_i[0]) begin
        commit_ack_o[0] = no_st_pending_i;
        fence_o         = no_st_pending_i;
      end

      // amo retires and flushes on the cache ack
      if (is_amo0) begin
        amo_valid_commit_o = 1'b1;
        commit_ack_o[0]    = amo_ack_i;
        flush_commit_o     = amo_ack_i;
        we_gpr_o[0]        = amo_ack_i;
      end
    end

    // port 1 only behind an acked port 0 that leaves the pipeline undisturbed
    port1_ok = commit_ack_o[0] && slot_ready_i[1] && slot_dual_ok_i[1]
               && !halt_i && !is_csr0 && !is_amo0
               && !single_step_i && !exception_valid_i;

    commit_ack_o[1] = port1_ok;
    we_gpr_o[1]     = port1_ok && !commit_drop_i[1] && !slot_fpr_dest_i[1];
    we_fpr_o[1]     = port1_ok && !commit_drop_i[1] && slot_fpr_dest_i[1];

    // fflags merge
    // port 0 flags are zero unless it is a live fpu op so OR covers both cases
    if (port1_ok && slot_fpu_i[1] && !commit_drop_i[1]) begin
      csr_wdata_o        = xlen_t'(slot_flags_i[0] | slot_flags_i[1]);
      csr_write_fflags_o = 1'b1;
    end
  end

  // ----------------------------------------
  // fp dirty
  // ----------------------------------------
  always_comb begin : dirty_fp
    dirty_fp_state_o = 1'b0;
    for (int i = 0; i < `NR_COMMIT_PORTS; i++) begin
      dirty_fp_state_o |= commit_ack_o[i] && (slot_fpu_i[i] || slot_fpr_dest_i[i]);
    end
  end

endmodule

//--- verilog/commit_exception.sv
// picks the exception taken at commit port 0, or none
`timescale 1ns/1ps
`include "commit_defines.svh"

module commit_exception (
  // port 0 entry
  input  logic                valid_i,
  input  logic                drop_i,
  input  logic                ex_valid_i,
  input  commit_pkg::cause_t  ex_cause_i,
  input  commit_pkg::xlen_t   ex_tval_i,
  // fault raised by the csr file for this entry
  input  logic                csr_exception_valid_i,
  input  commit_pkg::cause_t  csr_exception_cause_i,
  input  logic                halt_i,
  // trap request to the csr file
  output logic                exception_valid_o,
  output commit_pkg::cause_t  exception_cause_o,
  output commit_pkg::xlen_t   exception_tval_o
);

  always_comb begin : select_exception
    exception_valid_o = 1'b0;
    exception_cause_o = '0;
    exception_tval_o  = '0;

    // a dropped entry never traps
    if (valid_i && !drop_i) begin
      // csr fault keeps the tval the entry brought from decode
      if (csr_exception_valid_i) begin
        exception_valid_o = 1'b1;
        exception_cause_o = csr_exception_cause_i;
        exception_tval_o  = ex_tval_i;
      end
      // an earlier fault, e.g. a fetch page fault, has priority
      if (ex_valid_i) begin
        exception_valid_o = 1'b1;
        exception_cause_o = ex_cause_i;
        exception_tval_o  = ex_tval_i;
      end
    end

    // no trap while halted
    if (halt_i) begin
      exception_valid_o = 1'b0;
    end
  end

endmodule

//--- verilog/commit_slot.sv
// classifies one scoreboard entry for the commit controller, one instance per commit port
`timescale 1ns/1ps
`include "commit_defines.svh"

module commit_slot (
  // entry present at this port
  input  logic                valid_i,
  // unit and op of the entry
  input  commit_pkg::fu_t     fu_i,
  input  commit_pkg::fu_op_t  op_i,
  // exception carried by the entry
  input  logic                ex_valid_i,
  input  commit_pkg::cause_t  ex_cause_i,
  // entry is cancelled by the issue stage
  input  logic                drop_i,
  // entry can leave the scoreboard
  output logic                ready_o,
  // destination is the fp register file
  output logic                fpr_dest_o,
  // entry came from an fpu unit
  output logic                fpu_o,
  // unit allowed on the second port
  output logic                dual_ok_o,
  // fflags this entry contributes
  output commit_pkg::cause_t  flags_o
);

  // ----------------------------------------
  // retire check
  // ----------------------------------------
  // a faulting entry only leaves when it is dropped
  // the exception then never reaches the trap logic
  assign ready_o = valid_i && (!ex_valid_i || drop_i);

  // ----------------------------------------
  // classification
  // ----------------------------------------
  // op group in the upper nibble selects the fpr
  assign fpr_dest_o = (op_i[`FU_OP_BITS-1:`FU_OP_BITS-4] == `OP_FPR_GROUP);

  // scalar and vector fpu share the flag path
  assign fpu_o = (fu_i == `FU_FPU) || (fu_i == `FU_FPU_VEC);

  // single-cycle style units that can retire beside port 0
  // stores, csr and anything unknown stay on port 0
  assign dual_ok_o = fu_i inside {`FU_ALU, `FU_LOAD, `FU_CTRL_FLOW,
                                  `FU_MULT, `FU_FPU, `FU_FPU_VEC};

  // ----------------------------------------
  // fflags
  // ----------------------------------------
  // fpu results report their flags in the cause field
  // a dropped entry must not touch fflags
  assign flags_o = (fpu_o && !drop_i) ? ex_cause_i : '0;

endmodule

//--- verilog/commit_pkg.sv
// typedefs for the commit stage, imported by its modules and the testbench
`include "commit_defines.svh"

package commit_pkg;

  // one data word
  typedef logic [`XLEN-1:0] xlen_t;

  // program counter
  typedef logic [`VLEN-1:0] pc_t;

  // architectural register index, gpr or fpr
  typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;

  // function unit that executed the entry
  typedef logic [`FU_BITS-1:0] fu_t;

  // operation code, upper nibble selects the op group
  typedef logic [`FU_OP_BITS-1:0] fu_op_t;

  // scoreboard slot id
  typedef logic [`TRANS_ID_BITS-1:0] trans_id_t;

  // exception cause
  // fpu entries reuse the same bits for their fflags
  typedef logic [`CAUSE_BITS-1:0] cause_t;

  // one bit per commit port
  typedef logic [`NR_COMMIT_PORTS-1:0] port_vec_t;

endpackage

//--- include/commit_defines.svh
// widths, port count and unit/op encodings shared by the commit stage and its testbench
`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// ----------------------------------------
// sizes
// ----------------------------------------
// number of commit ports, the second port has its own rules
`define NR_COMMIT_PORTS 2
// integer data width
`define XLEN 32
// virtual pc width
`define VLEN 32
// scoreboard transaction id width
`define TRANS_ID_BITS 3
// register index, unit code, op code and cause widths
`define REG_ADDR_BITS 5
`define FU_BITS 4
`define FU_OP_BITS 8
`define CAUSE_BITS 5

// ----------------------------------------
// function-unit codes
// ----------------------------------------
`define FU_NONE      4'd0
`define FU_LOAD      4'd1
`define FU_STORE     4'd2
`define FU_ALU       4'd3
`define FU_CTRL_FLOW 4'd4
`define FU_MULT      4'd5
`define FU_CSR       4'd6
`define FU_FPU       4'd7
`define FU_FPU_VEC   4'd8

// ----------------------------------------
// operation codes
// ----------------------------------------
// add doubles as the csr no-op
`define OP_ADD     8'h00
`define OP_FENCE   8'h01
`define OP_FENCE_I 8'h02
// upper nibble of ops in the amo group
`define OP_AMO_GROUP 4'h3
// upper nibble of ops that write the fp register file
`define OP_FPR_GROUP 4'h5

`endif
